// ==== common/SpikeGenPkg.sv ====
package SpikeGenPkg;

  ///////////////////////////////
  // Widths and counts

  // Host word fields
  localparam int NPCcode = 8;
  localparam int NPCdata = 24;
  localparam int NPCin = NPCcode + NPCdata;

  // Spike events
  localparam int Ntag = 11;
  // Saturates at all ones
  localparam int Nct = 9;

  // Generator array
  localparam int Ngens = 8;
  localparam int NgenIdx = 3;
  localparam int Nperiod = 16;

  // Time unit length in clocks
  localparam int Nunit = 16;

  // Both IO FIFOs
  localparam int FIFOdepth = 4;

  ///////////////////////////////
  // Host opcodes

  localparam logic [NPCcode-1:0] CodeSetUnit = 8'd1;
  localparam logic [NPCcode-1:0] CodeSetTag = 8'd2;
  localparam logic [NPCcode-1:0] CodeSetGen = 8'd3;

  ///////////////////////////////
  // Payload types

  typedef struct packed {
    logic [NPCcode-1:0] code;
    logic [NPCdata-1:0] data;
  } PCWord;

  typedef struct packed {
    logic [Ntag-1:0] tag;
    logic [Nct-1:0] ct;
  } TagCt;

  // One per generator, written by the parser
  typedef struct packed {
    logic [Ntag-1:0] tag;
    logic [Nperiod-1:0] period;
    logic en;
  } GenConf;

endpackage

// ==== common/TagCtChannel.sv ====
// Spike event channel
// Transfer completes on a clk edge with v and a both high
interface TagCtChannel
  import SpikeGenPkg::*;
();

  // Payload, held stable by the producer while v waits for a
  logic [Ntag-1:0] tag;
  logic [Nct-1:0] ct;

  // Handshake
  logic v;
  logic a;

  // Generator or merger output side
  modport producer (output tag, ct, v, input a);

  // Merger input or FIFO side
  modport consumer (input tag, ct, v, output a);

endinterface

// ==== src/ChannelFIFO.sv ====
// Valid/ack FIFO, payload type set per instance
module ChannelFIFO
  import SpikeGenPkg::*;
#(
  parameter type T = PCWord
) (
  input  logic clk,
  input  logic arstN,
  input  T     inData,
  input  logic inV,
  output logic inA,
  output T     outData,
  output logic outV,
  input  logic outA
);

  // Storage, no reset
  T mem [FIFOdepth];

  logic [$clog2(FIFOdepth)-1:0] wrPtr;
  logic [$clog2(FIFOdepth)-1:0] rdPtr;
  logic [$clog2(FIFOdepth+1)-1:0] count;
  logic push;
  logic pop;

  // Accept whenever a slot is free
  assign inA = count != FIFOdepth;
  assign outV = count != 0;
  assign outData = mem[rdPtr];

  assign push = inV && inA;
  assign pop = outV && outA;

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wrPtr] <= inData;
    end
  end

  // Pointers wrap at the depth
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (push) begin
        wrPtr <= (wrPtr == FIFOdepth - 1) ? '0 : wrPtr + 1'b1;
      end
      if (pop) begin
        rdPtr <= (rdPtr == FIFOdepth - 1) ? '0 : rdPtr + 1'b1;
      end
      case ({push, pop})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // No write into a full buffer
  assert property (@(posedge clk) disable iff (!arstN)
    push |-> count < FIFOdepth)
    else $error("ChannelFIFO write accepted while full");

endmodule

// ==== src/PCParser.sv ====
// Host word decoder
// Word held one cycle, then written into the config registers
module PCParser
  import SpikeGenPkg::*;
(
  input  logic                    clk,
  input  logic                    arstN,
  input  PCWord                   inData,
  input  logic                    inV,
  output logic                    inA,
  output logic [Nunit-1:0]        unitLen,
  output GenConf [Ngens-1:0]      genConf,
  output logic [Ngens-1:0]        genRestart
);

  PCWord wordQ;
  logic wordV;
  logic [NgenIdx-1:0] idx;

  // Never stalls the input FIFO
  assign inA = inV;

  // Generator index sits in the top data bits
  assign idx = wordQ.data[NPCdata-1 -: NgenIdx];

  ///////////////////////////////
  // Capture stage

  always_ff @(posedge clk) begin
    if (inV) begin
      wordQ <= inData;
    end
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      wordV <= 1'b0;
    end else begin
      wordV <= inV;
    end
  end

  ///////////////////////////////
  // Config registers

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      unitLen <= '0;
      genConf <= '0;
    end else if (wordV) begin
      case (wordQ.code)
        CodeSetUnit: unitLen <= wordQ.data[Nunit-1:0];
        CodeSetTag: genConf[idx].tag <= wordQ.data[Ntag-1:0];
        CodeSetGen: begin
          genConf[idx].en <= wordQ.data[NPCdata-NgenIdx-1];
          genConf[idx].period <= wordQ.data[Nperiod-1:0];
        end
        // Unknown codes dropped
        default: ;
      endcase
    end
  end

  // Restart lands on the same edge as the new period
  always_comb begin
    for (int i = 0; i < Ngens; i++) begin
      genRestart[i] = wordV && (wordQ.code == CodeSetGen) && (idx == i);
    end
  end

endmodule

// ==== src/TimeMgr.sv ====
// Time unit pulse generator
module TimeMgr
  import SpikeGenPkg::*;
(
  input  logic             clk,
  input  logic             arstN,
  input  logic [Nunit-1:0] unitLen,
  output logic             unitPulse
);

  logic [Nunit-1:0] lenQ;
  logic [Nunit-1:0] cnt;
  logic lenChanged;
  logic wrap;

  // New length seen one cycle before the copy catches up
  assign lenChanged = unitLen != lenQ;
  assign wrap = cnt == unitLen - 1'b1;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      lenQ <= '0;
      cnt <= '0;
    end else begin
      lenQ <= unitLen;
      // Zero length parks the counter
      if (lenChanged || unitLen == '0 || wrap) begin
        cnt <= '0;
      end else begin
        cnt <= cnt + 1'b1;
      end
    end
  end

  // One cycle per unit, suppressed while the length settles
  assign unitPulse = !lenChanged && (unitLen != '0) && wrap;

endmodule

// ==== SpikeGen/SpikeGenerator.sv ====
// Single spike generator
// Counts time units, queues a spike every period
module SpikeGenerator
  import SpikeGenPkg::*;
(
  input  logic                 clk,
  input  logic                 arstN,
  input  GenConf               conf,
  input  logic                 restart,
  input  logic                 unitPulse,
  TagCtChannel.producer        out
);

  logic [Nperiod-1:0] unitCnt;
  logic [Nperiod-1:0] nextCnt;
  logic [Nct-1:0] pending;
  logic counting;
  logic fire;
  logic accepted;

  assign nextCnt = unitCnt + 1'b1;
  // Zero period or disabled means idle
  assign counting = unitPulse && conf.en && (conf.period != '0);
  // Restart wins over a coincident pulse
  assign fire = counting && !restart && (nextCnt == conf.period);
  assign accepted = out.v && out.a;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      unitCnt <= '0;
      pending <= '0;
    end else begin
      // Unit counter
      if (restart || fire) begin
        unitCnt <= '0;
      end else if (counting) begin
        unitCnt <= nextCnt;
      end
      // Pending spikes, saturating
      if (accepted) begin
        pending <= fire ? Nct'(1) : '0;
      end else if (fire && pending != '1) begin
        pending <= pending + 1'b1;
      end
    end
  end

  assign out.tag = conf.tag;
  assign out.ct = pending;
  assign out.v = pending != '0;

  // Waiting event never shrinks or vanishes before it is taken
  assert property (@(posedge clk) disable iff (!arstN)
    out.v && !out.a |=> out.v && (out.ct != '0) && (out.ct >= $past(out.ct)))
    else $error("SpikeGenerator lost pending count while waiting");

endmodule

// ==== SpikeGen/SpikeGenMerge.sv ====
// Round-robin merge of all generator channels
module SpikeGenMerge
  import SpikeGenPkg::*;
(
  input  logic             clk,
  input  logic             arstN,
  TagCtChannel.consumer    in [Ngens],
  TagCtChannel.producer    out
);

  logic [Ngens-1:0] reqV;
  TagCt reqData [Ngens];
  TagCt outQ;
  logic outV;
  logic load;
  logic grantAny;
  logic [NgenIdx-1:0] grantIdx;
  logic [NgenIdx-1:0] lastGrant;

  // Output slot free or draining this cycle
  assign load = !outV || out.a;

  ///////////////////////////////
  // Requests and acks

  for (genvar i = 0; i < Ngens; i++) begin : gReq
    assign reqV[i] = in[i].v;
    assign reqData[i] = {in[i].tag, in[i].ct};
    assign in[i].a = load && grantAny && (grantIdx == i);
  end

  // Search starts just past the last winner
  always_comb begin
    grantAny = 1'b0;
    grantIdx = lastGrant;
    for (int k = 1; k <= Ngens; k++) begin
      if (!grantAny && reqV[(int'(lastGrant) + k) % Ngens]) begin
        grantAny = 1'b1;
        grantIdx = NgenIdx'((int'(lastGrant) + k) % Ngens);
      end
    end
  end

  ///////////////////////////////
  // Output register

  always_ff @(posedge clk) begin
    if (load && grantAny) begin
      outQ <= reqData[grantIdx];
    end
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      outV <= 1'b0;
      lastGrant <= NgenIdx'(Ngens - 1);
    end else if (load) begin
      outV <= grantAny;
      if (grantAny) begin
        lastGrant <= grantIdx;
      end
    end
  end

  assign out.tag = outQ.tag;
  assign out.ct = outQ.ct;
  assign out.v = outV;

  // Stalled output must hold its event
  assert property (@(posedge clk) disable iff (!arstN)
    outV && !out.a |=> outV && $stable(outQ))
    else $error("SpikeGenMerge output changed while stalled");

endmodule

// ==== SpikeGen/SpikeGenArray.sv ====
// Generator bank plus merger
module SpikeGenArray
  import SpikeGenPkg::*;
(
  input  logic                clk,
  input  logic                arstN,
  input  GenConf [Ngens-1:0]  genConf,
  input  logic [Ngens-1:0]    genRestart,
  input  logic                unitPulse,
  TagCtChannel.producer       out
);

  // One channel per generator
  TagCtChannel genCh [Ngens] ();

  ///////////////////////////////
  // Generators

  for (genvar i = 0; i < Ngens; i++) begin : gGen
    SpikeGenerator gen (
      .clk(clk),
      .arstN(arstN),
      .conf(genConf[i]),
      .restart(genRestart[i]),
      .unitPulse(unitPulse),
      .out(genCh[i])
    );
  end

  ///////////////////////////////
  // Merge into one stream

  SpikeGenMerge merge (
    .clk(clk),
    .arstN(arstN),
    .in(genCh),
    .out(out)
  );

endmodule

// ==== src/SpikeGenCore.sv ====
// Host word in, tag/count events out
module SpikeGenCore
  import SpikeGenPkg::*;
(
  input  logic             clk,
  input  logic             arstN,
  // Host side
  input  logic [NPCin-1:0] pcInData,
  input  logic             pcInV,
  output logic             pcInA,
  // Event side
  output logic [Ntag-1:0]  tagOut,
  output logic [Nct-1:0]   ctOut,
  output logic             tagV,
  input  logic             tagA
);

  // Input FIFO to parser
  PCWord pcWord;
  logic pcWordV;
  logic pcWordA;

  // Config and timing
  logic [Nunit-1:0] unitLen;
  GenConf [Ngens-1:0] genConf;
  logic [Ngens-1:0] genRestart;
  logic unitPulse;

  // Merged events, before and after the output FIFO
  TagCtChannel mergedCh ();
  TagCt tagCtOut;

  ///////////////////////////////
  // Config path

  ChannelFIFO #(.T(PCWord)) inFifo (
    .clk(clk), .arstN(arstN),
    .inData(pcInData), .inV(pcInV), .inA(pcInA),
    .outData(pcWord), .outV(pcWordV), .outA(pcWordA)
  );

  PCParser pcParser (
    .clk(clk), .arstN(arstN),
    .inData(pcWord), .inV(pcWordV), .inA(pcWordA),
    .unitLen(unitLen), .genConf(genConf), .genRestart(genRestart)
  );

  TimeMgr timeMgr (.clk(clk), .arstN(arstN), .unitLen(unitLen), .unitPulse(unitPulse));

  ///////////////////////////////
  // Spike path

  SpikeGenArray genArray (
    .clk(clk), .arstN(arstN),
    .genConf(genConf), .genRestart(genRestart), .unitPulse(unitPulse),
    .out(mergedCh)
  );

  ChannelFIFO #(.T(TagCt)) outFifo (
    .clk(clk), .arstN(arstN),
    .inData({mergedCh.tag, mergedCh.ct}), .inV(mergedCh.v), .inA(mergedCh.a),
    .outData(tagCtOut), .outV(tagV), .outA(tagA)
  );

  assign tagOut = tagCtOut.tag;
  assign ctOut = tagCtOut.ct;

endmodule

// ==== test/SpikeGenChecker.sv ====
// Reference model of the config path, time unit and generators
// Compares every event leaving the DUT against the model
module SpikeGenChecker
  import SpikeGenPkg::*;
(
  input  logic             clk,
  input  logic             arstN,
  input  logic [NPCin-1:0] pcInData,
  input  logic             pcInV,
  input  logic             pcInA,
  input  logic [Ntag-1:0]  tagOut,
  input  logic [Nct-1:0]   ctOut,
  input  logic             tagV,
  input  logic             tagA,
  input  logic             compareNow,
  output int               errCount,
  output int               outstanding
);

  // Per-tag totals, model side and DUT side
  int expected [1 << Ntag];
  int received [1 << Ntag];

  // Host words in flight: FIFO output, then parser register
  PCWord stage1;
  PCWord stage2;
  logic stage1V;
  logic stage2V;

  // Modelled config and counters
  logic [Nunit-1:0] unitLen;
  logic [Nunit-1:0] lenQ;
  logic [Nunit-1:0] unitCnt;
  logic [Ntag-1:0] genTag [Ngens];
  logic [Nperiod-1:0] genPeriod [Ngens];
  logic [Nperiod-1:0] genCnt [Ngens];
  logic genEn [Ngens];
  logic [NgenIdx-1:0] idx;
  logic pulse;
  logic restart;

  // Stall tracking
  logic holdCheck;
  logic [Ntag-1:0] heldTag;
  logic [Nct-1:0] heldCt;

  int errs;
  int owed;

  always @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      for (int t = 0; t < (1 << Ntag); t++) begin
        expected[t] = 0;
        received[t] = 0;
      end
      for (int i = 0; i < Ngens; i++) begin
        genTag[i] = '0;
        genPeriod[i] = '0;
        genCnt[i] = '0;
        genEn[i] = 1'b0;
      end
      stage1 = '0;
      stage2 = '0;
      stage1V = 1'b0;
      stage2V = 1'b0;
      unitLen = '0;
      lenQ = '0;
      unitCnt = '0;
      holdCheck = 1'b0;
      heldTag = '0;
      heldCt = '0;
      errs = 0;
      owed = 0;
      errCount <= 0;
      outstanding <= 0;
    end else begin
      //////////////////////////////
      // Output side

      // A stalled event holds tag and ct
      if (holdCheck && (!tagV || tagOut != heldTag || ctOut != heldCt)) begin
        $display("[ERROR] %0t: event changed while tagA was low", $time);
        errs = errs + 1;
      end
      holdCheck = tagV && !tagA;
      heldTag = tagOut;
      heldCt = ctOut;

      if (tagV && tagA) begin
        if (ctOut == '0) begin
          $display("[ERROR] %0t: event for tag %0d with ct of zero", $time, tagOut);
          errs = errs + 1;
        end else if (received[tagOut] + ctOut > expected[tagOut]) begin
          $display("[ERROR] %0t: tag %0d got ct %0d beyond the %0d spikes due", $time,
                   tagOut, ctOut, expected[tagOut] - received[tagOut]);
          errs = errs + 1;
        end
        received[tagOut] = received[tagOut] + ctOut;
        owed = owed - ctOut;
      end

      //////////////////////////////
      // Time unit

      // Length change costs one dead cycle, then the count restarts
      pulse = (unitLen == lenQ) && (unitLen != '0) && (unitCnt + 1 == unitLen);
      if (unitLen != lenQ || unitLen == '0 || unitCnt + 1 == unitLen) begin
        unitCnt = '0;
      end else begin
        unitCnt = unitCnt + 1'b1;
      end
      lenQ = unitLen;

      // Generators, old config this edge
      for (int i = 0; i < Ngens; i++) begin
        restart = stage2V && (stage2.code == CodeSetGen) && (stage2.data[23:21] == i);
        if (restart) begin
          genCnt[i] = '0;
        end else if (pulse && genEn[i] && genPeriod[i] != '0) begin
          if (genCnt[i] + 1 == genPeriod[i]) begin
            genCnt[i] = '0;
            expected[genTag[i]] = expected[genTag[i]] + 1;
            owed = owed + 1;
          end else begin
            genCnt[i] = genCnt[i] + 1'b1;
          end
        end
      end

      //////////////////////////////
      // Config writes, two edges after acceptance

      if (stage2V) begin
        idx = stage2.data[23:21];
        case (stage2.code)
          CodeSetUnit: unitLen = stage2.data[15:0];
          CodeSetTag: genTag[idx] = stage2.data[10:0];
          CodeSetGen: begin
            genEn[idx] = stage2.data[20];
            genPeriod[idx] = stage2.data[15:0];
          end
          default: ;
        endcase
      end
      stage2V = stage1V;
      stage2 = stage1;
      stage1V = pcInV && pcInA;
      stage1 = pcInData;

      // End of test totals
      if (compareNow) begin
        for (int t = 0; t < (1 << Ntag); t++) begin
          if (expected[t] != received[t]) begin
            $display("[ERROR] %0t: tag %0d total ct %0d, model expects %0d", $time, t,
                     received[t], expected[t]);
            errs = errs + 1;
          end
        end
      end

      errCount <= errs;
      outstanding <= owed;
    end
  end

endmodule

// ==== test/SpikeGenTb.sv ====
module SpikeGenTb
  import SpikeGenPkg::*;
();

  localparam int ClkPeriod = 100;
  localparam int ResetCycles = 10;
  localparam logic [31:0] Seed = 32'hbce0;

  // Test lengths in cycles
  localparam int IdleCycles = 20;
  localparam int Win2 = 400;
  localparam int Win3 = 600;
  localparam int Win4 = 600;
  localparam int Win5 = 300;
  localparam int ConfigBudget = 200;
  localparam int DrainLimit = 500;
  localparam int SettleCycles = 20;
  localparam int WatchdogCycles = ResetCycles + IdleCycles + Win2 + Win3 + Win4 + 2 * Win5
    + 4 * (ConfigBudget + DrainLimit + SettleCycles + 8) + 1000;

  logic clk;
  logic arstN;
  logic [NPCin-1:0] pcInData;
  logic pcInV;
  logic pcInA;
  logic [Ntag-1:0] tagOut;
  logic [Nct-1:0] ctOut;
  logic tagV;
  logic tagA;

  logic compareNow;
  logic stallMode;
  int errCount;
  int outstanding;
  int tbErrors;
  int errMark;
  int testsRun;
  int testsFailed;
  logic [31:0] stimState;
  logic [31:0] stallState;
  int burstLeft;

  SpikeGenCore u_dut (
    .clk(clk), .arstN(arstN),
    .pcInData(pcInData), .pcInV(pcInV), .pcInA(pcInA),
    .tagOut(tagOut), .ctOut(ctOut), .tagV(tagV), .tagA(tagA)
  );

  SpikeGenChecker eventCheck (
    .clk(clk), .arstN(arstN),
    .pcInData(pcInData), .pcInV(pcInV), .pcInA(pcInA),
    .tagOut(tagOut), .ctOut(ctOut), .tagV(tagV), .tagA(tagA),
    .compareNow(compareNow), .errCount(errCount), .outstanding(outstanding)
  );

  //////////////////////////////
  // Helpers

  function automatic logic [31:0] lcgNext(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic drawRand(output logic [31:0] r);
    stimState = lcgNext(stimState);
    r = stimState;
  endtask

  function automatic logic [NPCdata-1:0] tagWord(input int idx, input logic [Ntag-1:0] tag);
    return {NgenIdx'(idx), 10'd0, tag};
  endfunction

  function automatic logic [NPCdata-1:0] genWord(input int idx, input logic en,
                                                 input logic [Nperiod-1:0] period);
    return {NgenIdx'(idx), en, 4'd0, period};
  endfunction

  // Called right after a rising edge, returns right after one
  task automatic sendWord(input logic [NPCcode-1:0] code, input logic [NPCdata-1:0] data);
    logic [31:0] r;
    pcInData <= {code, data};
    pcInV <= 1'b1;
    @(posedge clk);
    while (!pcInA) @(posedge clk);
    pcInV <= 1'b0;
    drawRand(r);
    repeat (r[17:16]) @(posedge clk);
  endtask

  task automatic configureAll();
    logic [31:0] r;
    for (int i = 0; i < Ngens; i++) begin
      drawRand(r);
      // Low bits from the index keep the tags distinct
      sendWord(CodeSetTag, tagWord(i, {r[23:16], NgenIdx'(i)}));
      drawRand(r);
      sendWord(CodeSetGen, genWord(i, 1'b1, Nperiod'(1 + r[18:16])));
    end
    drawRand(r);
    sendWord(CodeSetUnit, NPCdata'(2 + r[17:16]));
  endtask

  // Stop pulses, let the output empty, then compare totals
  task automatic stopAndDrain();
    int waited;
    waited = 0;
    sendWord(CodeSetUnit, '0);
    repeat (4) @(posedge clk);
    while ((outstanding != 0 || tagV) && waited < DrainLimit) begin
      @(posedge clk);
      waited++;
    end
    if (waited >= DrainLimit) begin
      $display("Output did not drain within %0d cycles", DrainLimit);
      tbErrors++;
    end
    repeat (SettleCycles) @(posedge clk);
    compareNow <= 1'b1;
    @(posedge clk);
    compareNow <= 1'b0;
    repeat (2) @(posedge clk);
  endtask

  task automatic finishTest(input string name);
    int now;
    now = errCount + tbErrors;
    testsRun++;
    if (now != errMark) begin
      testsFailed++;
      $display("Test %0d %s: failed with %0d errors", testsRun, name, now - errMark);
    end else begin
      $display("Test %0d %s: passed", testsRun, name);
    end
    errMark = now;
  endtask

  //////////////////////////////
  // Clock, stalls, watchdog

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  // Short tagA bursts keep pending counts far from saturation
  initial begin
    tagA = 1'b1;
    burstLeft = 0;
    stallState = ~Seed;
    forever begin
      @(posedge clk);
      stallState = lcgNext(stallState);
      if (burstLeft > 0) begin
        tagA <= 1'b0;
        burstLeft--;
      end else if (stallMode && stallState[31:29] == 3'd0) begin
        tagA <= 1'b0;
        burstLeft = stallState[17:16];
      end else begin
        tagA <= 1'b1;
      end
    end
  end

  initial begin
    #(WatchdogCycles * ClkPeriod);
    $display("Watchdog timed out after %0d cycles, the run did not finish", WatchdogCycles);
    $display("FAIL: see errors above");
    $finish;
  end

  //////////////////////////////
  // Test sequence

  initial begin
    logic [31:0] r;
    arstN = 1'b0;
    pcInData = '0;
    pcInV = 1'b0;
    compareNow = 1'b0;
    stallMode = 1'b0;
    stimState = Seed;
    tbErrors = 0;
    errMark = 0;
    testsRun = 0;
    testsFailed = 0;
    repeat (ResetCycles) @(posedge clk);
    arstN <= 1'b1;

    // Idle outputs before any config
    repeat (IdleCycles) begin
      @(posedge clk);
      if (tagV !== 1'b0 || pcInA !== 1'b1) begin
        $display("[ERROR] %0t: tagV %b pcInA %b after reset", $time, tagV, pcInA);
        tbErrors++;
      end
    end
    finishTest("after reset");

    // Generator 0 alone
    drawRand(r);
    sendWord(CodeSetTag, tagWord(0, r[26:16]));
    drawRand(r);
    sendWord(CodeSetGen, genWord(0, 1'b1, Nperiod'(2 + r[17:16])));
    drawRand(r);
    sendWord(CodeSetUnit, NPCdata'(3 + r[17:16]));
    repeat (Win2) @(posedge clk);
    stopAndDrain();
    finishTest("single generator");

    configureAll();
    repeat (Win3) @(posedge clk);
    stopAndDrain();
    finishTest("many generators");

    stallMode <= 1'b1;
    configureAll();
    repeat (Win4) @(posedge clk);
    stopAndDrain();
    stallMode <= 1'b0;
    finishTest("back-pressure");

    // Disable one, retime another, then an unknown opcode
    drawRand(r);
    sendWord(CodeSetUnit, NPCdata'(2 + r[17:16]));
    repeat (Win5) @(posedge clk);
    sendWord(CodeSetGen, genWord(0, 1'b0, 16'd1));
    drawRand(r);
    sendWord(CodeSetGen, genWord(1, 1'b1, Nperiod'(3 + r[19:16])));
    drawRand(r);
    sendWord({4'h1, r[19:16]}, r[23:0]);
    repeat (Win5) @(posedge clk);
    stopAndDrain();
    finishTest("reconfiguration");

    $display("Tests run %0d, passed %0d, failed %0d, errors %0d", testsRun,
             testsRun - testsFailed, testsFailed, errCount + tbErrors);
    if (testsFailed == 0 && errCount + tbErrors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// ==== build.f ====
common/SpikeGenPkg.sv
common/TagCtChannel.sv
src/ChannelFIFO.sv
src/PCParser.sv
src/TimeMgr.sv
SpikeGen/SpikeGenerator.sv
SpikeGen/SpikeGenMerge.sv
SpikeGen/SpikeGenArray.sv
src/SpikeGenCore.sv
test/SpikeGenChecker.sv
test/SpikeGenTb.sv

// ==== Bender.yml ====
package:
  name: spike_gen_path

sources:
  - common/SpikeGenPkg.sv
  - common/TagCtChannel.sv
  - src/ChannelFIFO.sv
  - src/PCParser.sv
  - src/TimeMgr.sv
  - SpikeGen/SpikeGenerator.sv
  - SpikeGen/SpikeGenMerge.sv
  - SpikeGen/SpikeGenArray.sv
  - src/SpikeGenCore.sv
  - target: test
    files:
      - test/SpikeGenChecker.sv
      - test/SpikeGenTb.sv
